/* verilog/wbh_bus_pkg.sv */
package wbh_bus_pkg;

   // --------------------------------------------------------------------------
   // internal host bus, one clock, plain level strobes
   // --------------------------------------------------------------------------
   parameter int ADR_W = 32;           // byte address
   parameter int DAT_W = 32;
   parameter int SEL_W = DAT_W / 8;    // one enable per byte

   // request after the host front end
   typedef struct packed {
      logic             we;            // 1 = write
      logic [ADR_W-1:0] adr;
      logic [DAT_W-1:0] dat;           // write data
      logic [SEL_W-1:0] sel;           // byte enables
   } wbh_req_t;

   // response from a target block, ack and err are one-cycle pulses
   typedef struct packed {
      logic             ack;
      logic             err;
      logic [DAT_W-1:0] dat;           // read data, valid with ack
   } wbh_rsp_t;

endpackage

/* verilog/wbh_cfg_pkg.sv */
package wbh_cfg_pkg;

   // --------------------------------------------------------------------------
   // local register space
   // --------------------------------------------------------------------------
   parameter int REG_SPACE_BIT = 19;   // adr[19] = 1 hits the local words
   parameter int REG_IDX_LSB   = 2;    // word index, adr[3:2]
   parameter int REG_IDX_MSB   = 3;

   // word order in the local space
   typedef enum logic [1:0] {
      glb_ctrl  = 2'd0,                // global control
      bank_sel  = 2'd1,                // upper address bank
      clk_ctrl1 = 2'd2,
      clk_ctrl2 = 2'd3
   } reg_idx_e;

   // --------------------------------------------------------------------------
   // bank select and address translation
   // --------------------------------------------------------------------------
   parameter int BANK_W = 16;
   typedef logic [BANK_W-1:0] bank_sel_t;

   // downstream adr = {bank[15:3], host adr[18:0]}
   parameter int BANK_KEEP_LSB = 3;
   parameter int LOCAL_ADR_MSB = 18;

   // global control word
   typedef struct packed {
      logic [30:0] spare;              // kept as plain storage
      logic        int_rst_en;         // drives the internal reset out
   } glb_ctrl_t;

endpackage

/* verilog/wbh_req_stage.sv */
`timescale 1ns/10ps

module wbh_req_stage
(
   input  logic                  wbm_clk_i,
   input  logic                  wbm_rst_n,
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  wbh_bus_pkg::wbh_req_t req_i,
   input  logic                  ack_pre_i,   // merged ack/err, not yet registered
   input  logic                  ack_i,       // registered ack/err toward the host
   output wbh_bus_pkg::wbh_req_t req_o,
   output logic                  reg_req_o,
   output logic                  fwd_req_o
);

   logic                  hold;               // any ack level seen
   logic                  stb_q;              // qualified strobe, first stage
   logic                  req_q;              // internal request level
   wbh_bus_pkg::wbh_req_t fld_q;              // captured request fields

   assign hold = ack_pre_i | ack_i;

   // --------------------------------------------------------------------------
   // strobe pipe, blocked around the ack so a held stb does not reissue
   // --------------------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         stb_q <= 1'b0;
         req_q <= 1'b0;
      end
      else
      begin
         stb_q <= cyc_i & stb_i & ~hold;   // cyc qualifies stb
         req_q <= stb_q & ~hold;
      end
   end

   // host holds the fields while stb is up
   always_ff @(posedge wbm_clk_i)
   begin
      if (cyc_i & stb_i)
         fld_q <= req_i;
   end

   assign req_o = fld_q;

   // local space vs downstream
   assign reg_req_o = req_q &  fld_q.adr[wbh_cfg_pkg::REG_SPACE_BIT];
   assign fwd_req_o = req_q & ~fld_q.adr[wbh_cfg_pkg::REG_SPACE_BIT];

   // request already low while the host sees the ack
   a_no_reissue: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      ack_i |-> !req_q);

endmodule

/* verilog/wbh_reg_bank.sv */
`timescale 1ns/10ps

module wbh_reg_bank
#(
   parameter wbh_cfg_pkg::bank_sel_t BANK_RST = 16'h1000
)
(
   input  logic                   wbm_clk_i,
   input  logic                   wbm_rst_n,
   input  wbh_bus_pkg::wbh_req_t  req_i,
   input  logic                   reg_req_i,
   output wbh_bus_pkg::wbh_rsp_t  rsp_o,
   output wbh_cfg_pkg::bank_sel_t bank_sel_o,
   output wbh_cfg_pkg::glb_ctrl_t glb_ctrl_o,
   output logic [31:0]            clk_ctrl1_o,
   output logic [31:0]            clk_ctrl2_o
);

   wbh_cfg_pkg::reg_idx_e         idx;        // word index from adr[3:2]
   logic                          acc;        // access taken this cycle
   logic                          wr_en;
   logic                          ack_q;
   logic [wbh_bus_pkg::DAT_W-1:0] rd_mux;
   logic [wbh_bus_pkg::DAT_W-1:0] rd_q;       // registered read data
   wbh_cfg_pkg::glb_ctrl_t        glb_q;
   wbh_cfg_pkg::bank_sel_t        bank_q;
   logic [31:0]                   clk1_q;
   logic [31:0]                   clk2_q;

   assign idx = wbh_cfg_pkg::reg_idx_e'(
                   req_i.adr[wbh_cfg_pkg::REG_IDX_MSB:wbh_cfg_pkg::REG_IDX_LSB]);

   assign acc   = reg_req_i & ~ack_q;        // ignore req while acking
   assign wr_en = acc & req_i.we;

   // --------------------------------------------------------------------------
   // configuration words
   // --------------------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_q  <= '0;
         bank_q <= BANK_RST;
         clk1_q <= '0;
         clk2_q <= '0;
      end
      else if (wr_en)
      begin
         case (idx)
            wbh_cfg_pkg::glb_ctrl  : glb_q  <= wbh_cfg_pkg::glb_ctrl_t'(req_i.dat);
            wbh_cfg_pkg::bank_sel  : bank_q <= req_i.dat[wbh_cfg_pkg::BANK_W-1:0];
            wbh_cfg_pkg::clk_ctrl1 : clk1_q <= req_i.dat;
            default                : clk2_q <= req_i.dat;
         endcase
      end
   end

   // read mux, bank select zero extended
   always_comb
   begin
      case (idx)
         wbh_cfg_pkg::glb_ctrl  : rd_mux = glb_q;
         wbh_cfg_pkg::bank_sel  :
            rd_mux = {{(wbh_bus_pkg::DAT_W-wbh_cfg_pkg::BANK_W){1'b0}}, bank_q};
         wbh_cfg_pkg::clk_ctrl1 : rd_mux = clk1_q;
         default                : rd_mux = clk2_q;
      endcase
   end

   // single-cycle ack, reads and writes alike
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         ack_q <= 1'b0;
      else
         ack_q <= acc;
   end

   always_ff @(posedge wbm_clk_i)
   begin
      if (acc & ~req_i.we)
         rd_q <= rd_mux;                     // capture on read only
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;                  // local space never errors
   assign rsp_o.dat = rd_q;

   assign bank_sel_o  = bank_q;
   assign glb_ctrl_o  = glb_q;
   assign clk_ctrl1_o = clk1_q;
   assign clk_ctrl2_o = clk2_q;

   // one ack per request, even with req still high
   a_ack_single: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      ack_q |-> ##2 !ack_q);

endmodule

/* verilog/wbh_fwd_port.sv */
`timescale 1ns/10ps

module wbh_fwd_port
(
   input  logic                          wbm_clk_i,
   input  logic                          wbm_rst_n,
   input  wbh_bus_pkg::wbh_req_t         req_i,
   input  logic                          fwd_req_i,
   input  wbh_cfg_pkg::bank_sel_t        bank_sel_i,
   output logic                          wbs_cyc_o,
   output logic                          wbs_stb_o,
   output logic                          wbs_we_o,
   output logic [wbh_bus_pkg::ADR_W-1:0] wbs_adr_o,
   output logic [wbh_bus_pkg::DAT_W-1:0] wbs_dat_o,
   output logic [wbh_bus_pkg::SEL_W-1:0] wbs_sel_o,
   input  logic [wbh_bus_pkg::DAT_W-1:0] wbs_dat_i,
   input  logic                          wbs_ack_i,
   input  logic                          wbs_err_i,
   output wbh_bus_pkg::wbh_rsp_t         rsp_o
);

   logic                          cyc_q;      // downstream cycle open
   logic                          start;
   logic                          done;       // slave answered this edge
   logic                          rsp_pend;   // response going out, no restart
   logic                          ack_q;
   logic                          err_q;
   logic [wbh_bus_pkg::DAT_W-1:0] rdat_q;
   logic [wbh_bus_pkg::ADR_W-1:0] adr_x;      // bank translated address

   // {bank[15:3], adr[18:0]}
   assign adr_x = {bank_sel_i[wbh_cfg_pkg::BANK_W-1:wbh_cfg_pkg::BANK_KEEP_LSB],
                   req_i.adr[wbh_cfg_pkg::LOCAL_ADR_MSB:0]};

   assign done     = cyc_q & (wbs_ack_i | wbs_err_i);
   assign rsp_pend = ack_q | err_q;
   assign start    = fwd_req_i & ~cyc_q & ~rsp_pend;

   // --------------------------------------------------------------------------
   // cycle control and response pulse
   // --------------------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         cyc_q <= 1'b0;
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end
      else
      begin
         ack_q <= cyc_q & wbs_ack_i;
         err_q <= cyc_q & wbs_err_i & ~wbs_ack_i;   // ack wins if both
         if (start)
            cyc_q <= 1'b1;
         else if (done)
            cyc_q <= 1'b0;
      end
   end

   // payload, steady through wait states
   always_ff @(posedge wbm_clk_i)
   begin
      if (start)
      begin
         wbs_adr_o <= adr_x;
         wbs_we_o  <= req_i.we;
         wbs_dat_o <= req_i.dat;
         wbs_sel_o <= req_i.sel;
      end
      if (cyc_q & wbs_ack_i)
         rdat_q <= wbs_dat_i;
   end

   assign wbs_cyc_o = cyc_q;
   assign wbs_stb_o = cyc_q;                  // stb follows cyc, single beat

   assign rsp_o.ack = ack_q;
   assign rsp_o.err = err_q;
   assign rsp_o.dat = rdat_q;

   // request withdrawn before the restart block lifts
   a_no_restart: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      rsp_pend |=> !fwd_req_i);

endmodule

/* verilog/wbh_resp_merge.sv */
`timescale 1ns/10ps

module wbh_resp_merge
(
   input  logic                  wbm_clk_i,
   input  logic                  wbm_rst_n,
   input  wbh_bus_pkg::wbh_rsp_t reg_rsp_i,
   input  wbh_bus_pkg::wbh_rsp_t fwd_rsp_i,
   output logic                  ack_pre_o,   // any termination, combinational
   output logic                  ack_o,       // registered termination
   output logic [31:0]           wbm_dat_o,
   output logic                  wbm_ack_o,
   output logic                  wbm_err_o
);

   logic                          any_ack;
   logic                          any_err;
   logic [wbh_bus_pkg::DAT_W-1:0] dat_sel;

   assign any_ack   = reg_rsp_i.ack | fwd_rsp_i.ack;
   assign any_err   = reg_rsp_i.err | fwd_rsp_i.err;
   assign ack_pre_o = any_ack | any_err;     // err also ends the request
   assign dat_sel   = reg_rsp_i.ack ? reg_rsp_i.dat : fwd_rsp_i.dat;

   // host response, data kept between acks
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbm_ack_o <= 1'b0;
         wbm_err_o <= 1'b0;
         wbm_dat_o <= '0;
      end
      else
      begin
         wbm_ack_o <= any_ack;
         wbm_err_o <= any_err & ~any_ack;
         if (any_ack)
            wbm_dat_o <= dat_sel;
      end
   end

   assign ack_o = wbm_ack_o | wbm_err_o;

   // req stage steers to one target only
   a_one_source: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !((reg_rsp_i.ack || reg_rsp_i.err) && (fwd_rsp_i.ack || fwd_rsp_i.err)));

endmodule

/* verilog/wb_host.sv */
`timescale 1ns/10ps

module wb_host
#(
   parameter wbh_cfg_pkg::bank_sel_t BANK_RST = 16'h1000
)
(
   input  logic                          wbm_clk_i,
   input  logic                          wbm_rst_n,
   // ---- host side
   input  logic                          wbm_cyc_i,
   input  logic                          wbm_stb_i,
   input  logic [wbh_bus_pkg::ADR_W-1:0] wbm_adr_i,
   input  logic                          wbm_we_i,
   input  logic [wbh_bus_pkg::DAT_W-1:0] wbm_dat_i,
   input  logic [wbh_bus_pkg::SEL_W-1:0] wbm_sel_i,
   output logic [wbh_bus_pkg::DAT_W-1:0] wbm_dat_o,
   output logic                          wbm_ack_o,
   output logic                          wbm_err_o,
   // ---- downstream slave
   output logic                          wbs_cyc_o,
   output logic                          wbs_stb_o,
   output logic [wbh_bus_pkg::ADR_W-1:0] wbs_adr_o,
   output logic                          wbs_we_o,
   output logic [wbh_bus_pkg::DAT_W-1:0] wbs_dat_o,
   output logic [wbh_bus_pkg::SEL_W-1:0] wbs_sel_o,
   input  logic [wbh_bus_pkg::DAT_W-1:0] wbs_dat_i,
   input  logic                          wbs_ack_i,
   input  logic                          wbs_err_i,
   // ---- config outputs
   output logic                          wbd_int_rst_o,
   output logic [31:0]                   cfg_clk_ctrl1_o,
   output logic [31:0]                   cfg_clk_ctrl2_o
);

   wbh_bus_pkg::wbh_req_t  host_req;          // raw host fields
   wbh_bus_pkg::wbh_req_t  req;               // registered request
   logic                   reg_req;
   logic                   fwd_req;
   logic                   ack_pre;
   logic                   ack;
   wbh_bus_pkg::wbh_rsp_t  reg_rsp;
   wbh_bus_pkg::wbh_rsp_t  fwd_rsp;
   wbh_cfg_pkg::bank_sel_t cfg_bank_sel;
   wbh_cfg_pkg::glb_ctrl_t cfg_glb_ctrl;

   assign host_req.we  = wbm_we_i;
   assign host_req.adr = wbm_adr_i;
   assign host_req.dat = wbm_dat_i;
   assign host_req.sel = wbm_sel_i;

   assign wbd_int_rst_o = cfg_glb_ctrl.int_rst_en;

   // --------------------------------------------------------------------------
   // request stage, then reg bank and forward port side by side
   // --------------------------------------------------------------------------
   wbh_req_stage u_req (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .cyc_i     (wbm_cyc_i), .stb_i     (wbm_stb_i),
      .req_i     (host_req),  .ack_pre_i (ack_pre),  .ack_i (ack),
      .req_o     (req),       .reg_req_o (reg_req),  .fwd_req_o (fwd_req));

   wbh_reg_bank #(.BANK_RST (BANK_RST)) u_regs (
      .wbm_clk_i   (wbm_clk_i),       .wbm_rst_n   (wbm_rst_n),
      .req_i       (req),             .reg_req_i   (reg_req),
      .rsp_o       (reg_rsp),         .bank_sel_o  (cfg_bank_sel),
      .glb_ctrl_o  (cfg_glb_ctrl),    .clk_ctrl1_o (cfg_clk_ctrl1_o),
      .clk_ctrl2_o (cfg_clk_ctrl2_o));

   wbh_fwd_port u_fwd (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .req_i     (req),       .fwd_req_i (fwd_req),   .bank_sel_i (cfg_bank_sel),
      .wbs_cyc_o (wbs_cyc_o), .wbs_stb_o (wbs_stb_o), .wbs_we_o   (wbs_we_o),
      .wbs_adr_o (wbs_adr_o), .wbs_dat_o (wbs_dat_o), .wbs_sel_o  (wbs_sel_o),
      .wbs_dat_i (wbs_dat_i), .wbs_ack_i (wbs_ack_i), .wbs_err_i  (wbs_err_i),
      .rsp_o     (fwd_rsp));

   // registered response back to the host
   wbh_resp_merge u_merge (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .reg_rsp_i (reg_rsp),   .fwd_rsp_i (fwd_rsp),
      .ack_pre_o (ack_pre),   .ack_o     (ack),
      .wbm_dat_o (wbm_dat_o), .wbm_ack_o (wbm_ack_o), .wbm_err_o (wbm_err_o));

endmodule

/* tests/tb_wb_slave_model.sv */
`timescale 1ns/10ps

module tb_wb_slave_model
(
   input  logic        wbm_clk_i,
   input  logic        wbm_rst_n,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic [31:0] adr_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        err_o
);

   integer     seed;                        // wait-state generator
   logic [1:0] wait_n;                      // wait states for this cycle
   logic [1:0] cnt;

   initial seed = 34;

   // registered answer, one pulse per downstream cycle
   always @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         ack_o  <= 1'b0;
         err_o  <= 1'b0;
         dat_o  <= '0;
         cnt    <= '0;
         wait_n <= '0;
      end
      else
      begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
         if (cyc_i && stb_i && !ack_o && !err_o)
         begin
            if (cnt == wait_n)
            begin
               cnt    <= '0;
               wait_n <= 2'($random(seed));   // 0..3 for the next cycle
               if (adr_i[18])
                  err_o <= 1'b1;              // bit 18 marks a bad target
               else
               begin
                  ack_o <= 1'b1;
                  dat_o <= ~adr_i;            // read data from the address
               end
            end
            else
               cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

/* tests/tb_wb_host.sv */
`timescale 1ns/10ps

module tb_wb_host;

   localparam int          N_TXN    = 30;              // host transactions in the run
   localparam logic [31:0] REG_BASE = 32'h0008_0000;   // adr[19] set

   // config outputs as one word
   typedef struct packed {
      logic        int_rst;
      logic [31:0] clk1;
      logic [31:0] clk2;
   } cfg_view_t;

   logic                  wbm_clk_i;
   logic                  wbm_rst_n;
   logic                  wbm_cyc_i;
   logic                  wbm_stb_i;
   logic                  wbm_we_i;
   logic [31:0]           wbm_adr_i;
   logic [31:0]           wbm_dat_i;
   logic [3:0]            wbm_sel_i;
   logic [31:0]           wbm_dat_o;
   logic                  wbm_ack_o;
   logic                  wbm_err_o;
   logic                  wbs_cyc_o;
   logic                  wbs_stb_o;
   logic [31:0]           wbs_dat_i;
   logic                  wbs_ack_i;
   logic                  wbs_err_i;
   wire wbh_bus_pkg::wbh_req_t dn_act;          // downstream request as driven
   wbh_bus_pkg::wbh_req_t dn_exp;               // same, rebuilt from host fields
   wire cfg_view_t        cfg_act;
   cfg_view_t             exp_cfg;
   logic [31:0]           shadow [4];           // host view of the local words
   logic [15:0]           exp_bank;
   logic [31:0]           exp_rdata;
   logic                  exp_err;
   int                    lat;                  // edges since stb came up
   int                    dn_cnt;               // slave answers in this request
   integer                seed;
   string                 test_name;

   assign exp_bank = shadow[1][15:0];
   assign exp_cfg  = {shadow[0][0], shadow[2], shadow[3]};
   assign dn_exp   = {wbm_we_i, exp_bank[15:3], wbm_adr_i[18:0], wbm_dat_i, wbm_sel_i};

   wb_host #(.BANK_RST (16'h1000)) uut (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .wbm_cyc_i (wbm_cyc_i), .wbm_stb_i (wbm_stb_i), .wbm_adr_i (wbm_adr_i),
      .wbm_we_i  (wbm_we_i),  .wbm_dat_i (wbm_dat_i), .wbm_sel_i (wbm_sel_i),
      .wbm_dat_o (wbm_dat_o), .wbm_ack_o (wbm_ack_o), .wbm_err_o (wbm_err_o),
      .wbs_cyc_o (wbs_cyc_o), .wbs_stb_o (wbs_stb_o), .wbs_adr_o (dn_act.adr),
      .wbs_we_o  (dn_act.we), .wbs_dat_o (dn_act.dat), .wbs_sel_o (dn_act.sel),
      .wbs_dat_i (wbs_dat_i), .wbs_ack_i (wbs_ack_i), .wbs_err_i (wbs_err_i),
      .wbd_int_rst_o (cfg_act.int_rst), .cfg_clk_ctrl1_o (cfg_act.clk1),
      .cfg_clk_ctrl2_o (cfg_act.clk2));

   tb_wb_slave_model u_slave (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n), .cyc_i (wbs_cyc_o),
      .stb_i (wbs_stb_o), .adr_i (dn_act.adr), .dat_o (wbs_dat_i),
      .ack_o (wbs_ack_i), .err_o (wbs_err_i));

   initial
   begin
      wbm_clk_i = 1'b0;
      forever #2 wbm_clk_i = ~wbm_clk_i;         // 4 ns period
   end

   // request age and downstream answer count
   always @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n || !(wbm_cyc_i && wbm_stb_i))
      begin
         lat    <= 0;
         dn_cnt <= 0;
      end
      else
      begin
         lat <= lat + 1;
         if (wbs_ack_i || wbs_err_i)
            dn_cnt <= dn_cnt + 1;
      end
   end

   task automatic stop_run;
      begin
         $display("TESTS FAILED");
         $fatal(1, "stopped at the first failing check");
      end
   endtask

   task automatic report_value(input string chk, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
      begin
         $display("ERR %s %s: expected %0h, actual %0h", test_name, chk, exp_v, act_v);
         stop_run();
      end
   endtask

   task automatic report_text(input string msg);
      begin
         $display("%s: %s", test_name, msg);
         stop_run();
      end
   endtask

   // ---------------------------------------------------------------------------
   // checks
   // ---------------------------------------------------------------------------
   a_resp_kind: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      (wbm_ack_o || wbm_err_o) |-> (wbm_err_o == exp_err && wbm_ack_o == !exp_err))
      else report_value("resp_kind", {exp_err, !exp_err}, {$sampled(wbm_err_o),
                        $sampled(wbm_ack_o)});
   a_one_pulse: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      (wbm_ack_o || wbm_err_o) |=> !(wbm_ack_o || wbm_err_o))
      else report_value("one_pulse", 0, 1);
   a_local_lat: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      (wbm_ack_o && wbm_adr_i[19]) |-> lat == 4)   // high right after E3
      else report_value("local_lat", 4, $sampled(lat));
   a_rd_data: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      (wbm_ack_o && !wbm_we_i) |-> wbm_dat_o == exp_rdata)
      else report_value("rd_data", exp_rdata, $sampled(wbm_dat_o));
   a_dat_hold: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      $changed(wbm_dat_o) |-> wbm_ack_o)
      else report_text("host read data changed without an ack");
   a_cfg_idle: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !(wbm_cyc_i && wbm_stb_i) |-> cfg_act == exp_cfg)
      else report_value("cfg_out", exp_cfg, $sampled(cfg_act));
   a_cfg_when: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      $changed(cfg_act) |-> (wbm_cyc_i && wbm_stb_i && wbm_we_i && wbm_adr_i[19]))
      else report_text("config output moved outside a local write");
   a_dn_req: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbs_stb_o |-> dn_act == dn_exp)              // translated adr and host fields
      else report_value("dn_req", $sampled(dn_exp), $sampled(dn_act));
   a_dn_hold: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      (wbs_stb_o && !wbs_ack_i && !wbs_err_i) |=> $stable(dn_act))
      else report_text("downstream request changed while the slave waited");
   a_dn_once: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbs_cyc_o |-> (wbm_cyc_i && wbm_stb_i && !wbm_adr_i[19] && dn_cnt == 0))
      else report_text("downstream cycle opened outside a single forwarded request");

   // expected read value of a local word
   function automatic logic [31:0] local_word(input logic [1:0] idx);
      if (idx == 2'd1)
         return {16'h0000, shadow[1][15:0]};        // bank select, low half only
      return shadow[idx];
   endfunction

   // one host access, held until ack or err
   task automatic run_access(input logic we, input logic [31:0] adr, input logic [31:0] dat);
      begin
         @(posedge wbm_clk_i);
         #1;
         exp_err   = adr[19] ? 1'b0 : adr[18];
         exp_rdata = adr[19] ? local_word(adr[3:2]) : ~{exp_bank[15:3], adr[18:0]};
         wbm_cyc_i = 1'b1;
         wbm_stb_i = 1'b1;
         wbm_we_i  = we;
         wbm_adr_i = adr;
         wbm_dat_i = dat;
         wbm_sel_i = dat[3:0];
         do
            @(posedge wbm_clk_i);
         while (!(wbm_ack_o || wbm_err_o));
         #1;
         wbm_cyc_i = 1'b0;
         wbm_stb_i = 1'b0;
         wbm_we_i  = 1'b0;
         if (we && adr[19])
            shadow[adr[3:2]] = dat;                  // word now holds the write
      end
   endtask

   task automatic forward_burst(input int n);
      logic [31:0] adr;
      logic [31:0] dat;
      begin
         repeat (n)
         begin
            adr     = $random(seed);
            adr[19] = 1'b0;                          // stay off the local space
            dat     = $random(seed);
            run_access(adr[0], adr, dat);            // adr[0] picks the direction
         end
      end
   endtask

   initial
   begin
      repeat (N_TXN * 200 + 10) @(posedge wbm_clk_i);
      report_text("watchdog expired before the transactions completed");
   end

   initial
   begin
      seed      = 34;
      test_name = "reset";
      shadow[0] = '0;
      shadow[1] = 32'h0000_1000;                     // bank select reset value
      shadow[2] = '0;
      shadow[3] = '0;
      wbm_rst_n = 1'b0;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
      wbm_adr_i = '0;
      wbm_dat_i = '0;
      wbm_sel_i = '0;
      repeat (10) @(posedge wbm_clk_i);
      #1 wbm_rst_n = 1'b1;
      test_name = "reset_values";
      run_access(1'b0, REG_BASE | 32'h4, '0);
      test_name = "local_rw";
      run_access(1'b1, REG_BASE | 32'h0, 32'hA5A5_0001);   // int reset on
      run_access(1'b1, REG_BASE | 32'h4, 32'hDEAD_2468);
      run_access(1'b1, REG_BASE | 32'h8, 32'h1234_5678);
      run_access(1'b1, REG_BASE | 32'hC, 32'h8765_4321);
      for (int i = 0; i < 4; i++)
         run_access(1'b0, REG_BASE | (i << 2), 32'h0);
      test_name = "int_rst_clear";
      run_access(1'b1, REG_BASE, 32'h0F0F_F0F0);
      run_access(1'b0, REG_BASE, 32'h0);
      test_name = "fwd_random";
      forward_burst(12);
      test_name = "fwd_new_bank";
      run_access(1'b1, REG_BASE | 32'h4, 32'h0000_BEEF);
      forward_burst(6);
      repeat (4) @(posedge wbm_clk_i);
      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* src.f */
verilog/wbh_bus_pkg.sv
verilog/wbh_cfg_pkg.sv
verilog/wbh_req_stage.sv
verilog/wbh_reg_bank.sv
verilog/wbh_fwd_port.sv
verilog/wbh_resp_merge.sv
verilog/wb_host.sv
tests/tb_wb_slave_model.sv
tests/tb_wb_host.sv
